// ==== include/ex_defs.svh ====
//////////////////////////////////////////////////
// Execute stage width definitions
// Data path and register index widths shared by
// the package and the rest of the design
//////////////////////////////////////////////////

`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// Data path width of the RV32 core
`define EX_XLEN 32

// Register file index width
`define EX_REG_AW 5

`endif

// ==== verilog/ex_pkg.sv ====
//////////////////////////////////////////////////
// Execute stage package
// Operation encodings, request and writeback
// records for the RV32 execute stage
//////////////////////////////////////////////////

`include "ex_defs.svh"

package ex_pkg;

  // Widths taken from the shared header
  localparam int XLEN         = `EX_XLEN;
  localparam int REG_AW       = `EX_REG_AW;
  // Cycles a multiply spends in EX
  localparam int MULT_LATENCY = 2;

  // Unit that executes the operation
  typedef enum logic [1:0] {
    UNIT_NONE, UNIT_ALU, UNIT_MULT, UNIT_BRANCH
  } unit_sel_e;

  // ALU operators, branch compares in the upper half
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_SLT, ALU_SLTU, ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
  } alu_op_e;

  // Multiplier operators
  typedef enum logic [1:0] {
    MUL_MUL, MUL_MULH, MUL_MULHU, MUL_MULHSU
  } mult_op_e;

  typedef logic [REG_AW-1:0] reg_addr_t;

  // Decoded instruction as issued into EX
  typedef struct packed {
    unit_sel_e       unit;
    alu_op_e         alu_op;
    mult_op_e        mult_op;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    // Branch target
    logic [XLEN-1:0] op_c;
    reg_addr_t       rd;
    logic            we;
  } ex_req_t;

  // Writeback record
  typedef struct packed {
    reg_addr_t       rd;
    logic [XLEN-1:0] data;
    logic            we;
  } wb_res_t;

endpackage

// ==== verilog/ex_op_if.sv ====
//////////////////////////////////////////////////
// EX operation interface
// One issued operation from ID/EX to the units
//////////////////////////////////////////////////

interface ex_op_if;

  // Operation held in EX is valid
  logic            valid;
  // Decoded operation fields, rd included
  ex_pkg::ex_req_t req;
  // EX completes and takes the next operation
  logic            advance;

  // ID/EX register side
  modport issue (
    output valid,
    output req,
    input  advance
  );

  // Units and result select
  // advance is driven by the result select only
  modport exec (
    input  valid,
    input  req,
    output advance
  );

endinterface

// ==== verilog/id_ex_reg.sv ====
//////////////////////////////////////////////////
// ID/EX pipeline register
// Holds the operation in EX until it completes
//////////////////////////////////////////////////

module id_ex_reg (
  input  logic            clk,
  input  logic            rst_n,

  // Upstream handshake
  input  logic            in_valid_i,
  input  ex_pkg::ex_req_t in_req_i,
  output logic            in_ready_o,

  // Operation towards the units
  ex_op_if.issue          op
);

  logic            valid_q;
  ex_pkg::ex_req_t req_q;

  // New operation only enters when EX moves on
  assign in_ready_o = op.advance;

  // Valid bit
  // A completed op without a successor leaves as a bubble
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      valid_q <= 1'b0;
    end
    else if (op.advance)
    begin
      valid_q <= in_valid_i;
    end
  end

  // Payload, loaded on accept only
  always_ff @(posedge clk)
  begin
    if (op.advance && in_valid_i)
    begin
      req_q <= in_req_i;
    end
  end

  assign op.valid = valid_q;
  assign op.req   = req_q;

endmodule

// ==== verilog/ex_alu.sv ====
//////////////////////////////////////////////////
// Execute stage ALU
// Arithmetic, logic, shifts, set-less-than and
// branch comparison in a single cycle
//////////////////////////////////////////////////

module ex_alu (
  ex_op_if.exec                  op,
  output logic [ex_pkg::XLEN-1:0] result_o,
  output logic                    cmp_taken_o
);

  logic [ex_pkg::XLEN-1:0] op_a;
  logic [ex_pkg::XLEN-1:0] op_b;
  logic [4:0]              shamt;
  logic                    eq;
  logic                    lt_s;
  logic                    lt_u;

  assign op_a  = op.req.op_a;
  assign op_b  = op.req.op_b;
  // RV32 uses the low five bits as shift amount
  assign shamt = op_b[4:0];

  // Shared comparators for slt and branches
  assign eq   = (op_a == op_b);
  assign lt_s = ($signed(op_a) < $signed(op_b));
  assign lt_u = (op_a < op_b);

  //////////////////////////////////////////////////
  // Branch decision
  //////////////////////////////////////////////////
  always_comb
  begin
    cmp_taken_o = 1'b0;
    case (op.req.alu_op)
      ex_pkg::ALU_BEQ:  cmp_taken_o = eq;
      ex_pkg::ALU_BNE:  cmp_taken_o = !eq;
      ex_pkg::ALU_BLT:  cmp_taken_o = lt_s;
      ex_pkg::ALU_BGE:  cmp_taken_o = !lt_s;
      ex_pkg::ALU_BLTU: cmp_taken_o = lt_u;
      ex_pkg::ALU_BGEU: cmp_taken_o = !lt_u;
      default:          cmp_taken_o = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Result
  //////////////////////////////////////////////////
  always_comb
  begin
    result_o = '0;
    case (op.req.alu_op)
      ex_pkg::ALU_ADD:  result_o = op_a + op_b;
      ex_pkg::ALU_SUB:  result_o = op_a - op_b;
      ex_pkg::ALU_AND:  result_o = op_a & op_b;
      ex_pkg::ALU_OR:   result_o = op_a | op_b;
      ex_pkg::ALU_XOR:  result_o = op_a ^ op_b;
      ex_pkg::ALU_SLL:  result_o = op_a << shamt;
      ex_pkg::ALU_SRL:  result_o = op_a >> shamt;
      // Arithmetic shift keeps the sign bit
      ex_pkg::ALU_SRA:  result_o = $unsigned($signed(op_a) >>> shamt);
      ex_pkg::ALU_SLT:  result_o = {{(ex_pkg::XLEN-1){1'b0}}, lt_s};
      ex_pkg::ALU_SLTU: result_o = {{(ex_pkg::XLEN-1){1'b0}}, lt_u};
      // Branch compares return the decision as a flag
      default:          result_o = {{(ex_pkg::XLEN-1){1'b0}}, cmp_taken_o};
    endcase
  end

endmodule

// ==== verilog/ex_mult.sv ====
//////////////////////////////////////////////////
// Execute stage multiplier
// Two-cycle 32x32 multiply for MUL, MULH, MULHU
// and MULHSU
//////////////////////////////////////////////////

module ex_mult (
  input  logic                    clk,
  input  logic                    rst_n,
  ex_op_if.exec                   op,
  output logic [ex_pkg::XLEN-1:0] result_o,
  output logic                    ready_o
);

  logic                              is_mul;
  logic                              busy_q;
  logic                              a_sign;
  logic                              b_sign;
  logic signed [2*ex_pkg::XLEN+1:0]  a_ext;
  logic signed [2*ex_pkg::XLEN+1:0]  b_ext;
  logic signed [2*ex_pkg::XLEN+1:0]  prod_full;
  logic        [2*ex_pkg::XLEN-1:0]  prod_q;

  assign is_mul = op.valid && (op.req.unit == ex_pkg::UNIT_MULT);

  // Operand signedness per operator
  // MUL takes the low word, so its sign does not matter
  assign a_sign = (op.req.mult_op == ex_pkg::MUL_MULH) ||
                  (op.req.mult_op == ex_pkg::MUL_MULHSU);
  assign b_sign = (op.req.mult_op == ex_pkg::MUL_MULH);

  // Operands extended to the product width, signed or unsigned
  assign a_ext     = {{(ex_pkg::XLEN+2){a_sign & op.req.op_a[ex_pkg::XLEN-1]}}, op.req.op_a};
  assign b_ext     = {{(ex_pkg::XLEN+2){b_sign & op.req.op_b[ex_pkg::XLEN-1]}}, op.req.op_b};
  assign prod_full = a_ext * b_ext;

  // Busy flag marks the second cycle of a multiply
  // Held until EX advances
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy_q <= 1'b0;
    end
    else if (is_mul && !busy_q)
    begin
      busy_q <= 1'b1;
    end
    else if (op.advance)
    begin
      busy_q <= 1'b0;
    end
  end

  // Product register, captured in the first cycle
  always_ff @(posedge clk)
  begin
    if (is_mul && !busy_q)
    begin
      prod_q <= prod_full[2*ex_pkg::XLEN-1:0];
    end
  end

  // Not ready during the first cycle of a multiply
  assign ready_o = !is_mul || busy_q;

  // Low word for MUL, high word for the rest
  assign result_o = (op.req.mult_op == ex_pkg::MUL_MUL) ?
                    prod_q[ex_pkg::XLEN-1:0] : prod_q[2*ex_pkg::XLEN-1:ex_pkg::XLEN];

endmodule

// ==== verilog/ex_wb_stage.sv ====
//////////////////////////////////////////////////
// Execute stage output side
// Result select, forwarding, branch report and
// the EX/WB register with its handshake
//////////////////////////////////////////////////

module ex_wb_stage (
  input  logic                    clk,
  input  logic                    rst_n,
  ex_op_if.exec                   op,

  // Unit results
  input  logic [ex_pkg::XLEN-1:0] alu_result_i,
  input  logic                    alu_taken_i,
  input  logic [ex_pkg::XLEN-1:0] mult_result_i,
  input  logic                    mult_ready_i,

  // Forwarding towards decode
  output logic                    fw_we_o,
  output ex_pkg::reg_addr_t       fw_waddr_o,
  output logic [ex_pkg::XLEN-1:0] fw_wdata_o,

  // Branch decision towards fetch
  output logic                    branch_valid_o,
  output logic                    branch_taken_o,
  output logic [ex_pkg::XLEN-1:0] branch_target_o,

  // Writeback handshake
  output logic                    wb_valid_o,
  output ex_pkg::wb_res_t         wb_res_o,
  input  logic                    wb_ready_i
);

  logic                    is_branch;
  logic                    wb_full_q;
  logic                    wb_free;
  logic                    retire;
  logic [ex_pkg::XLEN-1:0] ex_result;
  ex_pkg::wb_res_t         wb_res_q;

  assign is_branch = (op.req.unit == ex_pkg::UNIT_BRANCH);
  assign ex_result = (op.req.unit == ex_pkg::UNIT_MULT) ? mult_result_i : alu_result_i;

  // EX/WB slot can take a result this cycle
  assign wb_free = !wb_full_q || wb_ready_i;

  // Completion: units done, and a WB slot unless it is a branch
  // An empty EX always advances so a bubble is replaced
  assign op.advance = !op.valid || (mult_ready_i && (is_branch || wb_free));
  assign retire     = op.valid && op.advance;

  // Forwarding port shows the result on the leaving cycle
  assign fw_we_o    = retire && !is_branch && op.req.we;
  assign fw_waddr_o = op.req.rd;
  assign fw_wdata_o = ex_result;

  // Branches end here and never reach WB
  assign branch_valid_o  = retire && is_branch;
  assign branch_taken_o  = alu_taken_i;
  assign branch_target_o = op.req.op_c;

  //////////////////////////////////////////////////
  // EX/WB register
  //////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wb_full_q <= 1'b0;
    end
    else if (retire && !is_branch)
    begin
      wb_full_q <= 1'b1;
    end
    else if (wb_ready_i)
    begin
      // Drained with nothing new behind it
      wb_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (retire && !is_branch)
    begin
      wb_res_q <= '{rd: op.req.rd, data: ex_result, we: op.req.we};
    end
  end

  assign wb_valid_o = wb_full_q;
  assign wb_res_o   = wb_res_q;

endmodule

// ==== verilog/ex_stage.sv ====
//////////////////////////////////////////////////
// RV32 execute stage top level
// ID/EX register, ALU, multiplier and EX/WB side
//////////////////////////////////////////////////

module ex_stage (
  input  logic                    clk,
  input  logic                    rst_n,

  // Issue from decode
  input  logic                    valid_i,
  output logic                    ready_o,
  input  ex_pkg::unit_sel_e       unit_i,
  input  ex_pkg::alu_op_e         alu_op_i,
  input  ex_pkg::mult_op_e        mult_op_i,
  input  logic [ex_pkg::XLEN-1:0] op_a_i,
  input  logic [ex_pkg::XLEN-1:0] op_b_i,
  input  logic [ex_pkg::XLEN-1:0] op_c_i,
  input  ex_pkg::reg_addr_t       rd_i,
  input  logic                    we_i,

  // Forwarding
  output logic                    fw_we_o,
  output ex_pkg::reg_addr_t       fw_waddr_o,
  output logic [ex_pkg::XLEN-1:0] fw_wdata_o,

  // Branch decision
  output logic                    branch_valid_o,
  output logic                    branch_taken_o,
  output logic [ex_pkg::XLEN-1:0] branch_target_o,

  // Writeback
  output logic                    wb_valid_o,
  input  logic                    wb_ready_i,
  output ex_pkg::reg_addr_t       wb_rd_o,
  output logic                    wb_we_o,
  output logic [ex_pkg::XLEN-1:0] wb_data_o
);

  ex_pkg::ex_req_t         in_req;
  ex_pkg::wb_res_t         wb_res;
  logic [ex_pkg::XLEN-1:0] alu_result;
  logic                    alu_taken;
  logic [ex_pkg::XLEN-1:0] mult_result;
  logic                    mult_ready;

  // Pack the plain issue ports into one request
  assign in_req = '{unit: unit_i, alu_op: alu_op_i, mult_op: mult_op_i, op_a: op_a_i,
                    op_b: op_b_i, op_c: op_c_i, rd: rd_i, we: we_i};

  ex_op_if i_op_if ();

  id_ex_reg i_id_ex_reg (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid_i (valid_i),
    .in_req_i   (in_req),
    .in_ready_o (ready_o),
    .op         (i_op_if.issue)
  );

  ex_alu i_alu (
    .op          (i_op_if.exec),
    .result_o    (alu_result),
    .cmp_taken_o (alu_taken)
  );

  ex_mult i_mult (
    .clk      (clk),
    .rst_n    (rst_n),
    .op       (i_op_if.exec),
    .result_o (mult_result),
    .ready_o  (mult_ready)
  );

  ex_wb_stage i_wb_stage (
    .clk             (clk),
    .rst_n           (rst_n),
    .op              (i_op_if.exec),
    .alu_result_i    (alu_result),
    .alu_taken_i     (alu_taken),
    .mult_result_i   (mult_result),
    .mult_ready_i    (mult_ready),
    .fw_we_o         (fw_we_o),
    .fw_waddr_o      (fw_waddr_o),
    .fw_wdata_o      (fw_wdata_o),
    .branch_valid_o  (branch_valid_o),
    .branch_taken_o  (branch_taken_o),
    .branch_target_o (branch_target_o),
    .wb_valid_o      (wb_valid_o),
    .wb_res_o        (wb_res),
    .wb_ready_i      (wb_ready_i)
  );

  // Unpack the writeback record
  assign wb_rd_o   = wb_res.rd;
  assign wb_we_o   = wb_res.we;
  assign wb_data_o = wb_res.data;

endmodule

// ==== bench/tb_ex_stage.sv ====
//////////////////////////////////////////////////
// Execute stage testbench
// Replays the pattern file with random gaps and
// WB stalls, checks writeback, branch and
// forwarding ports
//////////////////////////////////////////////////

module tb_ex_stage;

  localparam int NUM_PAT    = 19;
  localparam int PAT_W      = 152;
  // Run limit in cycles, sized from the pattern count
  localparam int MAX_CYCLES = NUM_PAT * 4 * ex_pkg::MULT_LATENCY + 50;

  // Branch expectation with the cycle it must show up in
  typedef struct packed {
    logic                    taken;
    logic [ex_pkg::XLEN-1:0] target;
    logic [31:0]             due;
  } br_exp_t;

  logic                    clk;
  logic                    rst_n;
  logic                    valid_i;
  logic                    ready_o;
  ex_pkg::unit_sel_e       unit_i;
  ex_pkg::alu_op_e         alu_op_i;
  ex_pkg::mult_op_e        mult_op_i;
  logic [ex_pkg::XLEN-1:0] op_a_i;
  logic [ex_pkg::XLEN-1:0] op_b_i;
  logic [ex_pkg::XLEN-1:0] op_c_i;
  ex_pkg::reg_addr_t       rd_i;
  logic                    we_i;
  logic                    fw_we_o;
  ex_pkg::reg_addr_t       fw_waddr_o;
  logic [ex_pkg::XLEN-1:0] fw_wdata_o;
  logic                    branch_valid_o;
  logic                    branch_taken_o;
  logic [ex_pkg::XLEN-1:0] branch_target_o;
  logic                    wb_valid_o;
  logic                    wb_ready_i;
  ex_pkg::reg_addr_t       wb_rd_o;
  logic                    wb_we_o;
  logic [ex_pkg::XLEN-1:0] wb_data_o;

  // Pattern storage and scoreboard queues
  logic [PAT_W-1:0] pat_mem [0:31];
  logic [PAT_W-1:0] pat;
  ex_pkg::wb_res_t  wb_q [$];
  ex_pkg::wb_res_t  wb_exp;
  br_exp_t          br_q [$];
  br_exp_t          br_exp;
  logic [31:0]      rng_state;
  int               cycle_cnt;
  int               pat_idx;
  int               gap;
  int               fw_idx;
  // Forwarding writes seen and writes owed by accepted ops
  int               fw_cnt;
  int               fw_exp_cnt;
  int               stall_cnt;
  logic             done;

  ex_stage i_dut (
    .clk (clk), .rst_n (rst_n),
    .valid_i (valid_i), .ready_o (ready_o), .unit_i (unit_i), .alu_op_i (alu_op_i),
    .mult_op_i (mult_op_i), .op_a_i (op_a_i), .op_b_i (op_b_i), .op_c_i (op_c_i),
    .rd_i (rd_i), .we_i (we_i),
    .fw_we_o (fw_we_o), .fw_waddr_o (fw_waddr_o), .fw_wdata_o (fw_wdata_o),
    .branch_valid_o (branch_valid_o), .branch_taken_o (branch_taken_o),
    .branch_target_o (branch_target_o),
    .wb_valid_o (wb_valid_o), .wb_ready_i (wb_ready_i), .wb_rd_o (wb_rd_o),
    .wb_we_o (wb_we_o), .wb_data_o (wb_data_o)
  );

  always #2 clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Draw from 0 to range-1, upper LCG bits only
  function automatic int rand_below(input int range);
    rng_state = lcg_next(rng_state);
    return int'(rng_state[30:16]) % range;
  endfunction

  task automatic abort_run();
    $display("sim failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp)
    begin
      $display("[ERROR] %0t %s act=%b exp=%b", $time, name, act, exp);
      abort_run();
    end
  endtask

  task automatic check_wb(input ex_pkg::wb_res_t act, input ex_pkg::wb_res_t exp);
    if (act !== exp)
    begin
      $display("[ERROR] %0t wb_rd_o/wb_data_o/wb_we_o act=%0d/%h/%b exp=%0d/%h/%b",
               $time, act.rd, act.data, act.we, exp.rd, exp.data, exp.we);
      abort_run();
    end
  endtask

  task automatic check_branch(input logic taken_act, input logic taken_exp,
                              input logic [ex_pkg::XLEN-1:0] tgt_act,
                              input logic [ex_pkg::XLEN-1:0] tgt_exp);
    check_bit("branch_taken_o", taken_act, taken_exp);
    if (tgt_act !== tgt_exp)
    begin
      $display("[ERROR] %0t branch_target_o act=%h exp=%h", $time, tgt_act, tgt_exp);
      abort_run();
    end
  endtask

  task automatic check_fw(input ex_pkg::reg_addr_t addr_act, input ex_pkg::reg_addr_t addr_exp,
                          input logic [ex_pkg::XLEN-1:0] data_act,
                          input logic [ex_pkg::XLEN-1:0] data_exp);
    if (addr_act !== addr_exp || data_act !== data_exp)
    begin
      $display("[ERROR] %0t fw_waddr_o/fw_wdata_o act=%0d/%h exp=%0d/%h",
               $time, addr_act, data_act, addr_exp, data_exp);
      abort_run();
    end
  endtask

  // Present one pattern on the issue ports
  task automatic drive_pattern(input logic [PAT_W-1:0] p);
    valid_i   = 1'b1;
    unit_i    = ex_pkg::unit_sel_e'(p[149:148]);
    alu_op_i  = ex_pkg::alu_op_e'(p[147:144]);
    mult_op_i = ex_pkg::mult_op_e'(p[145:144]);
    op_a_i    = p[143:112];
    op_b_i    = p[111:80];
    op_c_i    = p[79:48];
    rd_i      = p[44:40];
    we_i      = p[36];
  endtask

  //////////////////////////////////////////////////
  // Stimulus and checking
  //////////////////////////////////////////////////
  initial
  begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    valid_i    = 1'b0;
    unit_i     = ex_pkg::UNIT_NONE;
    alu_op_i   = ex_pkg::ALU_ADD;
    mult_op_i  = ex_pkg::MUL_MUL;
    op_a_i     = '0;
    op_b_i     = '0;
    op_c_i     = '0;
    rd_i       = '0;
    we_i       = 1'b0;
    wb_ready_i = 1'b0;
    rng_state  = 32'd62;
    cycle_cnt  = 0;
    pat_idx    = 0;
    fw_cnt     = 0;
    fw_exp_cnt = 0;
    stall_cnt  = 0;
    done       = 1'b0;
    $readmemh("bench/ex_patterns.hex", pat_mem);
    // Every pattern names a unit, so a zero unit field means no entry
    if ($isunknown(pat_mem[NUM_PAT-1]) || pat_mem[NUM_PAT-1][151:148] == 4'h0)
    begin
      $display("pattern file is missing or holds fewer than %0d entries", NUM_PAT);
      abort_run();
    end

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    // Quiet outputs straight after reset
    check_bit("wb_valid_o", wb_valid_o, 1'b0);
    check_bit("branch_valid_o", branch_valid_o, 1'b0);
    check_bit("fw_we_o", fw_we_o, 1'b0);
    gap = rand_below(3);

    while (!done)
    begin
      @(negedge clk);
      cycle_cnt++;
      if (cycle_cnt > MAX_CYCLES)
      begin
        $display("timeout after %0d cycles with %0d results outstanding",
                 cycle_cnt, wb_q.size() + br_q.size());
        abort_run();
      end
      // Roughly one stalled WB cycle in four
      wb_ready_i = (rand_below(4) != 0);
      if (pat_idx < NUM_PAT && gap == 0)
      begin
        pat = pat_mem[pat_idx[4:0]];
        drive_pattern(pat);
      end
      else
      begin
        valid_i = 1'b0;
        if (gap > 0)
        begin
          gap--;
        end
      end
      #1;

      // Queue holds the WB entry, then the EX entry
      if (wb_q.size() > 2)
      begin
        $display("more results outstanding than the stage can hold at %0t", $time);
        abort_run();
      end
      if (fw_we_o)
      begin
        fw_idx = wb_valid_o ? 1 : 0;
        if (wb_q.size() <= fw_idx)
        begin
          $display("forwarding write with no operation in EX at %0t", $time);
          abort_run();
        end
        // An op with we low must not forward
        check_bit("fw_we_o", fw_we_o, wb_q[fw_idx].we);
        check_fw(fw_waddr_o, wb_q[fw_idx].rd, fw_wdata_o, wb_q[fw_idx].data);
        fw_cnt++;
      end
      // Full WB that is not drained blocks a result in EX
      if (wb_valid_o && !wb_ready_i && wb_q.size() == 2)
      begin
        check_bit("ready_o", ready_o, 1'b0);
        stall_cnt++;
      end

      if (branch_valid_o)
      begin
        if (br_q.size() == 0)
        begin
          $display("branch reported with no branch outstanding at %0t", $time);
          abort_run();
        end
        br_exp = br_q.pop_front();
        if (br_exp.due != cycle_cnt)
        begin
          $display("branch reported in cycle %0d instead of cycle %0d", cycle_cnt, br_exp.due);
          abort_run();
        end
        check_branch(branch_taken_o, br_exp.taken, branch_target_o, br_exp.target);
      end

      if (wb_valid_o && wb_ready_i)
      begin
        if (wb_q.size() == 0)
        begin
          $display("writeback with no result expected at %0t", $time);
          abort_run();
        end
        wb_exp = wb_q.pop_front();
        check_wb('{rd: wb_rd_o, data: wb_data_o, we: wb_we_o}, wb_exp);
      end

      // Accepted on the coming rising edge
      if (valid_i && ready_o)
      begin
        if (unit_i == ex_pkg::UNIT_BRANCH)
        begin
          br_q.push_back('{taken: pat[0], target: pat[79:48], due: cycle_cnt + 1});
        end
        else
        begin
          wb_q.push_back('{rd: pat[44:40], data: pat[35:4], we: pat[36]});
          if (pat[36])
          begin
            fw_exp_cnt++;
          end
        end
        pat_idx++;
        gap = rand_below(3);
      end
      done = (pat_idx == NUM_PAT) && (wb_q.size() == 0) && (br_q.size() == 0);
    end

    // One idle cycle, nothing may be written back twice
    @(negedge clk);
    valid_i    = 1'b0;
    wb_ready_i = 1'b1;
    #1;
    check_bit("wb_valid_o", wb_valid_o, 1'b0);
    check_bit("branch_valid_o", branch_valid_o, 1'b0);
    check_bit("fw_we_o", fw_we_o, 1'b0);

    // Each op with we high forwards exactly once as it leaves EX
    if (fw_cnt != fw_exp_cnt)
    begin
      $display("forwarding port showed %0d writes instead of %0d", fw_cnt, fw_exp_cnt);
      abort_run();
    end

    $display("%0d operations in %0d cycles, %0d stall cycles", NUM_PAT, cycle_cnt, stall_cnt);
    $display("sim passed");
    $finish;
  end

endmodule

// ==== ex_stage.f ====
+incdir+include
verilog/ex_pkg.sv
verilog/ex_op_if.sv
verilog/id_ex_reg.sv
verilog/ex_alu.sv
verilog/ex_mult.sv
verilog/ex_wb_stage.sv
verilog/ex_stage.sv
bench/tb_ex_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --top-module tb_ex_stage -Mdir obj_dir -f ex_stage.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_ex_stage > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "^sim passed$" "$LOG"; then
  echo "result: pass"
  exit 0
fi

echo "result: fail, see $LOG"
exit 1

// ==== bench/ex_patterns.hex ====
// unit_op_a_b_c_rd_we_expected_taken, all fields hex
// unit 1 ALU, 2 MULT, 3 BRANCH; op is the ALU or multiplier operator code
1_0_00000005_00000007_00000000_01_1_0000000c_0
2_0_00000007_00000006_00000000_0b_1_0000002a_0
1_1_00000003_00000005_00000000_02_1_fffffffe_0
2_1_80000000_00000002_00000000_0c_1_ffffffff_0
3_a_00000010_00000010_00001000_00_0_00000000_1
1_2_f0f0ff00_0ff0f0f0_00000000_03_1_00f0f000_0
2_2_ffffffff_ffffffff_00000000_0d_1_fffffffe_0
1_3_12340000_00005678_00000000_04_1_12345678_0
1_4_ffff0000_0f0f0f0f_00000000_05_1_f0f00f0f_0
3_c_ffffffff_00000000_00002000_00_0_00000000_1
2_3_fffffffe_80000000_00000000_0e_1_ffffffff_0
1_5_00000001_0000001f_00000000_06_1_80000000_0
1_6_80000000_00000004_00000000_07_1_08000000_0
1_7_80000000_00000004_00000000_08_1_f8000000_0
2_0_ffffffff_00000003_00000000_10_1_fffffffd_0
1_8_ffffffff_00000001_00000000_09_1_00000001_0
3_f_00000001_ffffffff_00003000_00_0_00000000_0
1_9_ffffffff_00000001_00000000_0a_1_00000000_0
1_0_00000100_00000023_00000000_1f_0_00000123_0
